// ==== Makefile ====
# Verilator build and run of the single-cycle MIPS core testbench

VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = mipsCoreTb
FILELIST  = mipsCore.f
OBJDIR    = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, pass only if the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== design/ctrlBus.sv ====
// decoded controls are levels valid for the current cycle only; rst is active low
`timescale 1ns/1ps

interface ctrlBus (
  input logic rst
);
  import mipsPkg::*;

  // write-back side
  logic    regDst;
  logic    memToReg;
  logic    regWrite;
  logic    link;

  // execute and memory side
  logic    aluSrc;
  aluCtrlT aluCtrl;
  logic    memWrite;

  // next-pc side
  logic    branch;
  logic    jump;
  logic    jumpReg;

  // decoder drives everything, sees reset for strobe gating
  modport producer (
    input  rst,
    output regDst, aluSrc, memToReg, regWrite, memWrite,
    output branch, jump, link, jumpReg, aluCtrl
  );

  // alu operand select and op
  modport exec (input aluSrc, aluCtrl, branch, memWrite);

  // pc redirect
  modport fetch (input jump, jumpReg, branch);

  // destination and data select
  modport wb (input regDst, memToReg, regWrite, link);

endinterface

// ==== design/decodeStage.sv ====
// unknown opcodes and function codes decode to a no-op; strobes forced low while rst is low
`timescale 1ns/1ps
`include "mipsSettings.svh"

module decodeStage (
  input  mipsPkg::wordT    instr,
  ctrlBus.producer         ctl,
  output mipsPkg::regAddrT rs,
  output mipsPkg::regAddrT rt,
  output mipsPkg::regAddrT rd,
  output mipsPkg::wordT    immExt,
  output logic [25:0]      jumpIndex
);
  import mipsPkg::*;

  opcodeT  opcode;
  functT   funct;
  aluCtrlT aluCtrlDec;
  logic    regWriteDec;
  logic    memWriteDec;

  // ========================================
  // field split
  // ========================================
  assign opcode    = instr[31:26];
  assign funct     = instr[5:0];
  assign rs        = instr[25:21];
  assign rt        = instr[20:16];
  assign rd        = instr[15:11];
  assign jumpIndex = instr[25:0];

  // sign extend 16-bit immediate
  assign immExt = {{16{instr[15]}}, instr[15:0]};

  // ========================================
  // control decode
  // ========================================
  always_comb begin
    // default is a no-op with an add on the alu
    ctl.regDst   = 1'b0;
    ctl.aluSrc   = 1'b0;
    ctl.memToReg = 1'b0;
    ctl.branch   = 1'b0;
    ctl.jump     = 1'b0;
    ctl.link     = 1'b0;
    ctl.jumpReg  = 1'b0;
    regWriteDec  = 1'b0;
    memWriteDec  = 1'b0;
    aluCtrlDec   = `MIPS_ALU_ADD;
    case (opcode)
      `MIPS_OP_RTYPE: begin
        ctl.regDst  = 1'b1;
        regWriteDec = 1'b1;
        case (funct)
          `MIPS_FN_ADD: aluCtrlDec = `MIPS_ALU_ADD;
          `MIPS_FN_SUB: aluCtrlDec = `MIPS_ALU_SUB;
          `MIPS_FN_AND: aluCtrlDec = `MIPS_ALU_AND;
          `MIPS_FN_OR:  aluCtrlDec = `MIPS_ALU_OR;
          `MIPS_FN_SLT: aluCtrlDec = `MIPS_ALU_SLT;
          `MIPS_FN_JR: begin
            // register jump, nothing written back
            ctl.jumpReg = 1'b1;
            regWriteDec = 1'b0;
          end
          default: regWriteDec = 1'b0;
        endcase
      end
      `MIPS_OP_LW: begin
        ctl.aluSrc   = 1'b1;
        ctl.memToReg = 1'b1;
        regWriteDec  = 1'b1;
      end
      `MIPS_OP_SW: begin
        ctl.aluSrc  = 1'b1;
        memWriteDec = 1'b1;
      end
      `MIPS_OP_BEQ: begin
        // compare by subtraction
        ctl.branch = 1'b1;
        aluCtrlDec = `MIPS_ALU_SUB;
      end
      `MIPS_OP_J: ctl.jump = 1'b1;
      `MIPS_OP_JAL: begin
        ctl.jump    = 1'b1;
        ctl.link    = 1'b1;
        regWriteDec = 1'b1;
      end
      default: ;
    endcase
  end

  assign ctl.aluCtrl = aluCtrlDec;

  // no state may change while in reset
  assign ctl.regWrite = regWriteDec & ctl.rst;
  assign ctl.memWrite = memWriteDec & ctl.rst;

endmodule

// ==== design/executeStage.sv ====
// slt is signed; no overflow detection on add or sub
`timescale 1ns/1ps
`include "mipsSettings.svh"

module executeStage (
  ctrlBus.exec          ctl,
  input  mipsPkg::wordT rsValue,
  input  mipsPkg::wordT rtValue,
  input  mipsPkg::wordT immExt,
  input  mipsPkg::wordT pcPlus4,
  output mipsPkg::wordT aluResult,
  output logic          zero,
  output mipsPkg::wordT branchTarget
);
  import mipsPkg::*;

  wordT    opA;
  wordT    opB;
  wordT    branchOffset;
  logic    lessThan;

  // ========================================
  // operand select
  // ========================================

  // rs is always the first operand
  assign opA = rsValue;

  // immediate for lw and sw, rt otherwise
  assign opB = ctl.aluSrc ? immExt : rtValue;

  // signed compare for slt
  assign lessThan = $signed(opA) < $signed(opB);

  // ========================================
  // alu
  // ========================================

  // lw and sw decode to add, giving base plus offset
  always_comb begin
    case (ctl.aluCtrl)
      `MIPS_ALU_ADD: aluResult = opA + opB;
      `MIPS_ALU_SUB: aluResult = opA - opB;
      `MIPS_ALU_AND: aluResult = opA & opB;
      `MIPS_ALU_OR:  aluResult = opA | opB;
      `MIPS_ALU_SLT: aluResult = {31'd0, lessThan};
      // unused encodings fall back to add
      default:       aluResult = opA + opB;
    endcase
  end

  // beq equality, also valid for any other op
  assign zero = (aluResult == '0);

  // ========================================
  // branch target
  // ========================================

  // word offset, only applied for beq
  assign branchOffset = ctl.branch ? {immExt[29:0], 2'b00} : '0;

  // relative to the instruction after the branch
  assign branchTarget = pcPlus4 + branchOffset;

endmodule

// ==== design/fetchStage.sv ====
// pc is the only fetch state; no delay slot, jump region taken from pc plus 4
`timescale 1ns/1ps
`include "mipsSettings.svh"

module fetchStage (
  input  logic          clk,
  input  logic          rst,
  ctrlBus.fetch         ctl,
  input  logic          zero,
  input  mipsPkg::wordT branchTarget,
  input  logic [25:0]   jumpIndex,
  input  mipsPkg::wordT jumpRegValue,
  output mipsPkg::wordT pc,
  output mipsPkg::wordT pcPlus4
);
  import mipsPkg::*;

  wordT jumpTarget;
  wordT pcNext;
  logic takeBranch;

  // ========================================
  // next pc candidates
  // ========================================

  // sequential
  assign pcPlus4 = pc + 32'd4;

  // j and jal keep the top nibble of the next pc
  assign jumpTarget = {pcPlus4[31:28], jumpIndex, 2'b00};

  // beq taken when sub result is zero
  assign takeBranch = ctl.branch & zero;

  // priority jr, j/jal, beq, fall-through
  always_comb begin
    if (ctl.jumpReg) begin
      pcNext = jumpRegValue;
    end else if (ctl.jump) begin
      pcNext = jumpTarget;
    end else if (takeBranch) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // ========================================
  // pc register
  // ========================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pcNext;
    end
  end

endmodule

// ==== design/mipsCore.sv ====
// memories are external and combinational; memWen is active low, no stall input
`timescale 1ns/1ps
`include "mipsSettings.svh"

module mipsCore (
  input  logic              clk,
  input  logic              rst,
  input  mipsPkg::wordT     instr,
  output mipsPkg::wordT     irAddr,
  output mipsPkg::dmemAddrT memAddr,
  output mipsPkg::wordT     memWrData,
  input  mipsPkg::wordT     memRdData,
  output logic              memWen,
  output logic              rfWriteEn,
  output mipsPkg::regAddrT  rfWriteAddr,
  output mipsPkg::wordT     rfWriteData
);
  import mipsPkg::*;

  wordT        pcPlus4;
  wordT        immExt;
  wordT        rsValue;
  wordT        rtValue;
  wordT        aluResult;
  wordT        branchTarget;
  logic        zero;
  logic [25:0] jumpIndex;
  regAddrT     rs;
  regAddrT     rt;
  regAddrT     rd;

  // decoded controls shared by all stages
  ctrlBus ctl (.rst(rst));

  // ========================================
  // stage chain
  // ========================================
  fetchStage u_fetchStage (
    .clk(clk), .rst(rst), .ctl(ctl), .zero(zero), .branchTarget(branchTarget),
    .jumpIndex(jumpIndex), .jumpRegValue(rsValue), .pc(irAddr), .pcPlus4(pcPlus4)
  );

  decodeStage u_decodeStage (
    .instr(instr), .ctl(ctl), .rs(rs), .rt(rt), .rd(rd),
    .immExt(immExt), .jumpIndex(jumpIndex)
  );

  executeStage u_executeStage (
    .ctl(ctl), .rsValue(rsValue), .rtValue(rtValue), .immExt(immExt),
    .pcPlus4(pcPlus4), .aluResult(aluResult), .zero(zero), .branchTarget(branchTarget)
  );

  writebackRegs u_writebackRegs (
    .clk(clk), .rst(rst), .ctl(ctl), .rs(rs), .rt(rt), .rd(rd),
    .aluResult(aluResult), .memRdData(memRdData), .pcPlus4(pcPlus4),
    .rsValue(rsValue), .rtValue(rtValue),
    .wrEn(rfWriteEn), .wrAddr(rfWriteAddr), .wrData(rfWriteData)
  );

  // ========================================
  // data memory port
  // ========================================

  // word index from the byte address
  assign memAddr   = aluResult[`MIPS_DMEM_AW+1:2];
  assign memWrData = rtValue;

  // memWrite is low in reset, so this idles high
  assign memWen = ~ctl.memWrite;

endmodule

// ==== design/mipsPkg.sv ====
// shared vector types only; dmemAddrT width follows MIPS_DMEM_AW at compile time
`include "mipsSettings.svh"

package mipsPkg;

  // ========================================
  // datapath widths
  // ========================================

  // data words and byte addresses
  typedef logic [31:0] wordT;

  // register file index
  typedef logic [4:0] regAddrT;

  // ========================================
  // instruction fields
  // ========================================

  // bits 31:26
  typedef logic [5:0] opcodeT;

  // bits 5:0, r-type only
  typedef logic [5:0] functT;

  // ========================================
  // control and memory
  // ========================================

  // alu operation, see MIPS_ALU_* codes
  typedef logic [2:0] aluCtrlT;

  // data memory word index, byte address bits AW+1:2
  typedef logic [`MIPS_DMEM_AW-1:0] dmemAddrT;

endpackage

// ==== design/mipsSettings.svh ====
// assumes word-addressed data memory of 2**MIPS_DMEM_AW words; only aligned word accesses
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// ========================================
// primary opcodes
// ========================================
`define MIPS_OP_RTYPE 6'b000000
`define MIPS_OP_LW    6'b100011
`define MIPS_OP_SW    6'b101011
`define MIPS_OP_BEQ   6'b000100
`define MIPS_OP_J     6'b000010
`define MIPS_OP_JAL   6'b000011

// r-type function codes
`define MIPS_FN_ADD 6'b100000
`define MIPS_FN_SUB 6'b100010
`define MIPS_FN_AND 6'b100100
`define MIPS_FN_OR  6'b100101
`define MIPS_FN_SLT 6'b101010
`define MIPS_FN_JR  6'b001000

// alu selector encodings
`define MIPS_ALU_AND 3'b000
`define MIPS_ALU_OR  3'b001
`define MIPS_ALU_ADD 3'b010
`define MIPS_ALU_SUB 3'b110
`define MIPS_ALU_SLT 3'b111

// first fetch address, data memory word address width, jal target reg
`define MIPS_RESET_PC 32'h0000_0000
`define MIPS_DMEM_AW  7
`define MIPS_LINK_REG 5'd31

`endif

// ==== design/writebackRegs.sv ====
// register 0 is hardwired zero; writes land on the rising edge, reads are combinational
`timescale 1ns/1ps
`include "mipsSettings.svh"

module writebackRegs (
  input  logic             clk,
  input  logic             rst,
  ctrlBus.wb               ctl,
  input  mipsPkg::regAddrT rs,
  input  mipsPkg::regAddrT rt,
  input  mipsPkg::regAddrT rd,
  input  mipsPkg::wordT    aluResult,
  input  mipsPkg::wordT    memRdData,
  input  mipsPkg::wordT    pcPlus4,
  output mipsPkg::wordT    rsValue,
  output mipsPkg::wordT    rtValue,
  output logic             wrEn,
  output mipsPkg::regAddrT wrAddr,
  output mipsPkg::wordT    wrData
);
  import mipsPkg::*;

  // 32 general purpose registers
  wordT regs [32];

  // ========================================
  // write-back select
  // ========================================

  // jal to r31, r-type to rd, lw to rt
  assign wrAddr = ctl.link   ? `MIPS_LINK_REG :
                  ctl.regDst ? rd : rt;

  // link value, load data, or alu
  assign wrData = ctl.link     ? pcPlus4   :
                  ctl.memToReg ? memRdData : aluResult;

  // regWrite already low in reset; drop writes to r0
  assign wrEn = ctl.regWrite && (wrAddr != '0);

  // ========================================
  // register array
  // ========================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // read ports, r0 forced to zero
  assign rsValue = (rs == '0) ? '0 : regs[rs];
  assign rtValue = (rt == '0) ? '0 : regs[rt];

endmodule

// ==== mipsCore.f ====
+incdir+design
+incdir+tb
design/mipsPkg.sv
design/ctrlBus.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/writebackRegs.sv
design/mipsCore.sv
tb/mipsCoreTb.sv

// ==== tb/mipsRefModel.svh ====
// included inside the testbench module after its memories and model state are declared
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

// final self-loop of the test program
localparam wordT END_PC = 32'd92;

// ========================================
// instruction encoders
// ========================================
function automatic wordT rType(input functT fn, input regAddrT rd, input regAddrT rs,
                               input regAddrT rt);
  return {`MIPS_OP_RTYPE, rs, rt, rd, 5'd0, fn};
endfunction

function automatic wordT iType(input opcodeT op, input regAddrT rs, input regAddrT rt,
                               input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

// target is a byte address in the same 256 MB region
function automatic wordT jType(input opcodeT op, input wordT target);
  return {op, target[27:2]};
endfunction

// ========================================
// test program and data
// ========================================
task automatic loadProgram();
  // unused words hold an undefined opcode tagged with their index
  for (int i = 0; i < IMEM_WORDS; i++) begin
    imem[i] = {6'h3f, 26'(i)};
  end
  // operands from random data words
  imem[0]  = iType(`MIPS_OP_LW, 5'd0, 5'd1, 16'd0);
  imem[1]  = iType(`MIPS_OP_LW, 5'd0, 5'd2, 16'd4);
  imem[2]  = iType(`MIPS_OP_LW, 5'd0, 5'd3, 16'd8);
  imem[3]  = rType(`MIPS_FN_ADD, 5'd4, 5'd1, 5'd2);
  imem[4]  = rType(`MIPS_FN_SUB, 5'd5, 5'd1, 5'd2);
  imem[5]  = rType(`MIPS_FN_AND, 5'd6, 5'd1, 5'd3);
  imem[6]  = rType(`MIPS_FN_OR, 5'd7, 5'd2, 5'd3);
  imem[7]  = rType(`MIPS_FN_SLT, 5'd8, 5'd1, 5'd2);
  imem[8]  = rType(`MIPS_FN_SLT, 5'd9, 5'd2, 5'd1);
  // store then reload the same word
  imem[9]  = iType(`MIPS_OP_SW, 5'd0, 5'd4, 16'd12);
  imem[10] = iType(`MIPS_OP_LW, 5'd0, 5'd10, 16'd12);
  // write to r0 is dropped, r0 then read as zero
  imem[11] = rType(`MIPS_FN_ADD, 5'd0, 5'd1, 5'd2);
  imem[12] = rType(`MIPS_FN_OR, 5'd11, 5'd0, 5'd1);
  // counted loop, count and step from data words 16 and 17
  imem[13] = iType(`MIPS_OP_LW, 5'd0, 5'd12, 16'd64);
  imem[14] = iType(`MIPS_OP_LW, 5'd0, 5'd13, 16'd68);
  imem[15] = rType(`MIPS_FN_SUB, 5'd12, 5'd12, 5'd13);
  imem[16] = rType(`MIPS_FN_ADD, 5'd14, 5'd14, 5'd1);
  imem[17] = iType(`MIPS_OP_BEQ, 5'd12, 5'd0, 16'd1);
  // back four words to the loop head at 60
  imem[18] = iType(`MIPS_OP_BEQ, 5'd0, 5'd0, 16'hfffc);
  // call, store the sum, then skip over one word
  imem[19] = jType(`MIPS_OP_JAL, 32'd96);
  imem[20] = iType(`MIPS_OP_SW, 5'd0, 5'd14, 16'd16);
  imem[21] = jType(`MIPS_OP_J, END_PC);
  imem[22] = rType(`MIPS_FN_ADD, 5'd15, 5'd1, 5'd1);
  imem[23] = iType(`MIPS_OP_BEQ, 5'd0, 5'd0, 16'hffff);
  // subroutine copies the link and returns
  imem[24] = rType(`MIPS_FN_OR, 5'd16, 5'd31, 5'd0);
  imem[25] = rType(`MIPS_FN_JR, 5'd0, 5'd31, 5'd0);
endtask

task automatic fillDataMemory();
  for (int i = 0; i < DMEM_WORDS; i++) begin
    dmem[i] = $random(seed);
  end
  // opposite signs, so slt differs from an unsigned compare
  dmem[0][31] = 1'b1;
  dmem[1][31] = 1'b0;
  // loop count and step
  dmem[16] = 32'd3;
  dmem[17] = 32'd1;
  refDmem = dmem;
endtask

// ========================================
// instruction-set reference
// ========================================
function automatic void stepRef(
  input  wordT     pcIn,
  input  wordT     instrIn,
  input  wordT     regsIn [32],
  input  wordT     memIn [DMEM_WORDS],
  output wordT     pcNext,
  output logic     wbEn,
  output regAddrT  wbAddr,
  output wordT     wbData,
  output logic     mwEn,
  output dmemAddrT mwAddr,
  output wordT     mwData
);
  opcodeT op;
  functT  fn;
  wordT   a;
  wordT   b;
  wordT   imm;
  wordT   ea;
  wordT   seqPc;
  op     = instrIn[31:26];
  fn     = instrIn[5:0];
  a      = regsIn[instrIn[25:21]];
  b      = regsIn[instrIn[20:16]];
  imm    = {{16{instrIn[15]}}, instrIn[15:0]};
  ea     = a + imm;
  seqPc  = pcIn + 32'd4;
  pcNext = seqPc;
  wbEn   = 1'b0;
  wbAddr = '0;
  wbData = '0;
  mwEn   = 1'b0;
  mwAddr = '0;
  mwData = '0;
  case (op)
    `MIPS_OP_RTYPE: begin
      wbEn   = 1'b1;
      wbAddr = instrIn[15:11];
      case (fn)
        `MIPS_FN_ADD: wbData = a + b;
        `MIPS_FN_SUB: wbData = a - b;
        `MIPS_FN_AND: wbData = a & b;
        `MIPS_FN_OR:  wbData = a | b;
        `MIPS_FN_SLT: wbData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        `MIPS_FN_JR: begin
          wbEn   = 1'b0;
          pcNext = a;
        end
        default: wbEn = 1'b0;
      endcase
    end
    `MIPS_OP_LW: begin
      wbEn   = 1'b1;
      wbAddr = instrIn[20:16];
      wbData = memIn[ea[`MIPS_DMEM_AW+1:2]];
    end
    `MIPS_OP_SW: begin
      mwEn   = 1'b1;
      mwAddr = ea[`MIPS_DMEM_AW+1:2];
      mwData = b;
    end
    `MIPS_OP_BEQ: begin
      if (a == b) begin
        pcNext = seqPc + (imm << 2);
      end
    end
    `MIPS_OP_J: pcNext = {seqPc[31:28], instrIn[25:0], 2'b00};
    `MIPS_OP_JAL: begin
      pcNext = {seqPc[31:28], instrIn[25:0], 2'b00};
      wbEn   = 1'b1;
      wbAddr = `MIPS_LINK_REG;
      wbData = seqPc;
    end
    default: ;
  endcase
  // r0 never takes a write
  if (wbAddr == 5'd0) begin
    wbEn = 1'b0;
  end
endfunction

`endif

// ==== tb/mipsCoreTb.sv ====
// combinational memory models; run stops at the program's self-loop or after 2000 cycles
`timescale 1ns/1ps
`include "mipsSettings.svh"

module mipsCoreTb;
  import mipsPkg::*;

  localparam int IMEM_WORDS   = 64;
  localparam int DMEM_WORDS   = 1 << `MIPS_DMEM_AW;
  localparam int RESET_CYCLES = 5;
  localparam int MAX_CYCLES   = 2000;

  // dut ports
  logic     clk;
  logic     rst;
  wordT     instr;
  wordT     irAddr;
  dmemAddrT memAddr;
  wordT     memWrData;
  wordT     memRdData;
  logic     memWen;
  logic     rfWriteEn;
  regAddrT  rfWriteAddr;
  wordT     rfWriteData;

  // memories and model state
  wordT   imem [IMEM_WORDS];
  wordT   dmem [DMEM_WORDS];
  wordT   refDmem [DMEM_WORDS];
  wordT   refRegs [32];
  wordT   refPc;
  integer seed = 32'h8f4d_3911;

  // run bookkeeping
  int   checks;
  int   errors;
  int   otherErrors;
  int   cycles;
  logic checking;
  logic reachedEnd;

  `include "mipsRefModel.svh"

  mipsCore u_mipsCore (
    .clk(clk), .rst(rst), .instr(instr), .irAddr(irAddr), .memAddr(memAddr),
    .memWrData(memWrData), .memRdData(memRdData), .memWen(memWen),
    .rfWriteEn(rfWriteEn), .rfWriteAddr(rfWriteAddr), .rfWriteData(rfWriteData)
  );

  // ========================================
  // clock and memory models
  // ========================================
  always #10 clk = ~clk;

  assign instr     = imem[irAddr[7:2]];
  assign memRdData = dmem[memAddr];

  // store lands at the edge that ends the sw cycle
  always @(posedge clk) begin
    if (!memWen) begin
      dmem[memAddr] = memWrData;
    end
  end

  // ========================================
  // checking
  // ========================================
  task automatic checkValue(input string name, input wordT actual, input wordT expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // one instruction against the model, then advance the model
  task automatic compareStep();
    wordT     curInstr;
    wordT     expPc;
    logic     expWbEn;
    regAddrT  expWbAddr;
    wordT     expWbData;
    logic     expMwEn;
    dmemAddrT expMwAddr;
    wordT     expMwData;
    curInstr = imem[refPc[7:2]];
    stepRef(refPc, curInstr, refRegs, refDmem, expPc, expWbEn, expWbAddr, expWbData,
            expMwEn, expMwAddr, expMwData);
    checkValue("irAddr", irAddr, refPc);
    checkValue("rfWriteEn", 32'(rfWriteEn), 32'(expWbEn));
    if (expWbEn) begin
      checkValue("rfWriteAddr", 32'(rfWriteAddr), 32'(expWbAddr));
      checkValue("rfWriteData", rfWriteData, expWbData);
      refRegs[expWbAddr] = expWbData;
    end
    // memWen is active low
    checkValue("memWen", 32'(memWen), 32'(!expMwEn));
    if (expMwEn) begin
      checkValue("memAddr", 32'(memAddr), 32'(expMwAddr));
      checkValue("memWrData", memWrData, expMwData);
      refDmem[expMwAddr] = expMwData;
    end
    if (irAddr == END_PC) begin
      reachedEnd = 1'b1;
    end
    refPc = expPc;
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (checking && !reachedEnd) begin
      compareStep();
    end
  end

  // ========================================
  // main sequence
  // ========================================
  initial begin
    clk         = 1'b0;
    rst         = 1'b0;
    checks      = 0;
    errors      = 0;
    otherErrors = 0;
    checking    = 1'b0;
    reachedEnd  = 1'b0;
    refPc       = `MIPS_RESET_PC;
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = '0;
    end
    loadProgram();
    fillDataMemory();

    // idle outputs while in reset
    @(negedge clk);
    checkValue("irAddr", irAddr, `MIPS_RESET_PC);
    checkValue("rfWriteEn", 32'(rfWriteEn), 32'd0);
    checkValue("memWen", 32'(memWen), 32'd1);
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(posedge clk);
    end
    #2 rst = 1'b1;
    checking = 1'b1;

    // until the self-loop is fetched
    cycles = 0;
    while (!reachedEnd && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    checking = 1'b0;
    if (!reachedEnd) begin
      otherErrors++;
      $display("Timeout: the program did not reach its end within %0d cycles", MAX_CYCLES);
    end

    $display("Summary: %0d checks, %0d mismatches, %0d other errors", checks, errors,
             otherErrors);
    if (errors == 0 && otherErrors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
